/* common/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W       = 64;
    localparam int LINE_W       = 128;
    localparam int WORD_W       = 64;
    localparam int OFFS_W       = 1;
    localparam int BYTE_W       = 3;
    localparam int STRB_W       = 8;
    localparam int DEF_SET_BITS = 7;

    // Supported set index range, sizes the shared tag and set fields
    localparam int SET_MIN_W = 6;
    localparam int SET_MAX_W = 8;
    localparam int TAG_MAX_W = ADDR_W - SET_MIN_W - OFFS_W - BYTE_W;

    typedef struct packed {
        logic [ADDR_W-DEF_SET_BITS-OFFS_W-BYTE_W-1:0] tag;
        logic [DEF_SET_BITS-1:0]                      set;
        logic [OFFS_W-1:0]                            offs;
        logic [BYTE_W-1:0]                            bsel;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw; // Whole word, memory side
        addr_fields_t      f;
    } cpu_addr_u;

    typedef struct packed {
        logic              valid;
        logic              write; // 0 read, 1 write
        cpu_addr_u         addr;
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic                 err;
        logic [TAG_MAX_W-1:0] tag;
    } line_meta_t;

    typedef enum logic [2:0] {
        WR_NONE,
        WR_STORE,
        WR_REFILL,
        WR_CLEAN,
        WR_TOUCH
    } arr_kind_e;

    typedef struct packed {
        arr_kind_e            kind;
        logic                 way;
        logic [SET_MAX_W-1:0] set;
        logic [LINE_W-1:0]    line;
        logic [TAG_MAX_W-1:0] tag;
        logic                 err;
        logic [STRB_W-1:0]    strb;
        logic [OFFS_W-1:0]    offs;
        logic [WORD_W-1:0]    word;
    } arr_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        WRBACK,
        REFILL,
        FENCE_WALK,
        FENCE_WB
    } mctl_state_e;

endpackage

/* dcache/dcache_lookup.sv */
`timescale 1ns/100ps

module dcache_lookup import dcache_pkg::*; #(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic       clk,
    input  logic       rst,
    input  cpu_req_t   req,
    input  line_meta_t meta0,
    input  line_meta_t meta1,
    input  logic       recent,
    input  logic       busy,
    output logic       ok,
    output logic       hit_way,
    output logic       miss,
    output logic       victim_way,
    output logic       victim_dirty,
    output arr_wr_t    lk_cmd
);
    localparam int TAG_W = ADDR_W - SET_BITS - OFFS_W - BYTE_W;

    logic [TAG_W-1:0]    req_tag;
    logic [SET_BITS-1:0] req_set;
    logic                hit0;
    logic                hit1;
    logic                pick;
    logic                victim_q;

    assign req_tag = req.addr.raw[ADDR_W-1 -: TAG_W];
    assign req_set = req.addr.raw[OFFS_W+BYTE_W +: SET_BITS];

    assign hit0    = meta0.valid && (meta0.tag == TAG_MAX_W'(req_tag));
    assign hit1    = meta1.valid && (meta1.tag == TAG_MAX_W'(req_tag));
    assign hit_way = hit1;
    assign ok      = req.valid && (hit0 || hit1) && !busy;
    assign miss    = req.valid && !(hit0 || hit1) && !busy;

    // Invalid way, then the lone clean way, then LRU
    always_comb begin
        if (!meta0.valid)
            pick = 1'b0;
        else if (!meta1.valid)
            pick = 1'b1;
        else if (meta0.dirty != meta1.dirty)
            pick = meta0.dirty;
        else
            pick = !recent;
    end

    // Victim frozen for the whole miss
    always_ff @(posedge clk) begin
        if (rst)
            victim_q <= 1'b0;
        else if (miss)
            victim_q <= pick;
    end

    assign victim_way   = busy ? victim_q : pick;
    assign victim_dirty = pick ? (meta1.valid && meta1.dirty) : (meta0.valid && meta0.dirty);

    always_comb begin
        lk_cmd = '0;
        if (ok) begin
            lk_cmd.kind = req.write ? WR_STORE : WR_TOUCH; // Both update recency
            lk_cmd.way  = hit1;
            lk_cmd.set  = SET_MAX_W'(req_set);
            lk_cmd.strb = req.strb;
            lk_cmd.offs = req.addr.f.offs;
            lk_cmd.word = req.wdata;
        end
    end

endmodule

/* dcache/dcache_arrays.sv */
`timescale 1ns/100ps

module dcache_arrays import dcache_pkg::*; #(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [SET_BITS-1:0]  set,
    input  arr_wr_t              cmd,
    input  logic                 rd_en,
    input  logic                 rd_way,
    input  logic [OFFS_W-1:0]    rd_offs,
    input  logic [SET_BITS:0]    wb_sel,
    output line_meta_t           meta0,
    output line_meta_t           meta1,
    output logic                 recent,
    output logic [WORD_W-1:0]    rdata,
    output logic                 rdata_err,
    output logic [LINE_W-1:0]    wb_line,
    output logic [TAG_MAX_W-1:0] wb_tag,
    output logic                 wb_dirty
);
    localparam int SETS  = 1 << SET_BITS;
    localparam int TAG_W = ADDR_W - SET_BITS - OFFS_W - BYTE_W;

    logic [LINE_W-1:0]   data_q   [2][SETS];
    logic [TAG_W-1:0]    tag_q    [2][SETS];
    logic                err_q    [2][SETS];
    logic                valid_q  [2][SETS];
    logic                dirty_q  [2][SETS];
    logic                recent_q [SETS];
    logic [SET_BITS-1:0] cset;
    logic [SET_BITS-1:0] wset;
    logic                wway;

    function automatic line_meta_t meta_of(input logic way);
        line_meta_t m;
        m.valid = valid_q[way][set];
        m.dirty = dirty_q[way][set];
        m.err   = err_q[way][set];
        m.tag   = TAG_MAX_W'(tag_q[way][set]);
        return m;
    endfunction

    assign cset = cmd.set[SET_BITS-1:0];
    assign wset = wb_sel[SET_BITS:1];
    assign wway = wb_sel[0];

    always_comb begin
        meta0 = meta_of(1'b0);
        meta1 = meta_of(1'b1);
    end

    assign recent = recent_q[set];

    // Write-back / fence port
    assign wb_line  = data_q[wway][wset];
    assign wb_tag   = TAG_MAX_W'(tag_q[wway][wset]);
    assign wb_dirty = valid_q[wway][wset] && dirty_q[wway][wset];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[0][s] <= 1'b0;
                valid_q[1][s] <= 1'b0;
                dirty_q[0][s] <= 1'b0;
                dirty_q[1][s] <= 1'b0;
                recent_q[s]   <= 1'b0;
            end
        end else begin
            case (cmd.kind)
                WR_STORE: begin
                    dirty_q[cmd.way][cset] <= 1'b1;
                    recent_q[cset]         <= cmd.way;
                end
                WR_TOUCH: recent_q[cset] <= cmd.way;
                WR_REFILL: begin
                    valid_q[cmd.way][cset] <= 1'b1;
                    dirty_q[cmd.way][cset] <= 1'b0;
                end
                WR_CLEAN: dirty_q[cmd.way][cset] <= 1'b0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.kind == WR_STORE) begin
            // Byte merge into the addressed half
            for (int b = 0; b < STRB_W; b++) begin
                if (cmd.strb[b])
                    data_q[cmd.way][cset][cmd.offs*WORD_W + b*8 +: 8] <= cmd.word[b*8 +: 8];
            end
        end else if (cmd.kind == WR_REFILL) begin
            data_q[cmd.way][cset] <= cmd.line;
            tag_q[cmd.way][cset]  <= cmd.tag[TAG_W-1:0];
            err_q[cmd.way][cset]  <= cmd.err; // Sticky until the line is replaced
        end
        if (rd_en) begin
            rdata     <= data_q[rd_way][set][rd_offs*WORD_W +: WORD_W];
            rdata_err <= err_q[rd_way][set];
        end
    end

endmodule

/* dcache/dcache_miss_ctrl.sv */
`timescale 1ns/100ps

module dcache_miss_ctrl import dcache_pkg::*; #(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_req_t             req,
    input  logic                 miss,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  logic                 fence,
    input  logic [LINE_W-1:0]    wb_line,
    input  logic [TAG_MAX_W-1:0] wb_tag,
    input  logic                 wb_dirty,
    output logic                 busy,
    output logic [SET_BITS:0]    wb_sel,
    output arr_wr_t              ctl_cmd,
    output logic                 rd_req,
    output logic [ADDR_W-1:0]    rd_addr,
    input  logic                 rd_ready,
    input  logic                 rd_err,
    input  logic [LINE_W-1:0]    rd_data,
    output logic                 wr_req,
    output logic [ADDR_W-1:0]    wr_addr,
    output logic [LINE_W-1:0]    wr_data,
    input  logic                 wr_ready
);
    localparam int LOW_W = OFFS_W + BYTE_W;
    localparam int TAG_W = ADDR_W - SET_BITS - LOW_W;

    mctl_state_e         state;
    logic [SET_BITS:0]   walk; // {set, way}, way toggles fastest
    logic [SET_BITS-1:0] req_set;
    logic [SET_BITS-1:0] wb_set;
    logic                fencing;
    logic                last;

    assign req_set = req.addr.raw[LOW_W +: SET_BITS];
    assign fencing = (state == FENCE_WALK) || (state == FENCE_WB);
    assign wb_sel  = fencing ? walk : {req_set, victim_way};
    assign wb_set  = wb_sel[SET_BITS:1];
    assign last    = &walk;
    assign busy    = state != IDLE;

    assign rd_req  = state == REFILL;
    assign rd_addr = {req.addr.raw[ADDR_W-1:LOW_W], {LOW_W{1'b0}}};
    assign wr_req  = (state == WRBACK) || (state == FENCE_WB);
    assign wr_addr = {wb_tag[TAG_W-1:0], wb_set, {LOW_W{1'b0}}}; // Rebuilt from stored tag
    assign wr_data = wb_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            walk  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fence) begin
                        state <= FENCE_WALK;
                        walk  <= '0;
                    end else if (miss) begin
                        state <= victim_dirty ? WRBACK : REFILL;
                    end
                end
                WRBACK: if (wr_ready) state <= REFILL;
                REFILL: if (rd_ready) state <= IDLE;
                FENCE_WALK: begin
                    if (wb_dirty)
                        state <= FENCE_WB;
                    else if (last)
                        state <= IDLE;
                    else
                        walk <= walk + 1'b1; // Clean line, skip
                end
                FENCE_WB: begin
                    if (wr_ready) begin
                        if (last) begin
                            state <= IDLE;
                        end else begin
                            walk  <= walk + 1'b1;
                            state <= FENCE_WALK;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Array updates land on the ready edges
    always_comb begin
        ctl_cmd = '0;
        if (((state == WRBACK) || (state == FENCE_WB)) && wr_ready) begin
            ctl_cmd.kind = WR_CLEAN;
            ctl_cmd.way  = wb_sel[0];
            ctl_cmd.set  = SET_MAX_W'(wb_set);
        end else if ((state == REFILL) && rd_ready) begin
            ctl_cmd.kind = WR_REFILL;
            ctl_cmd.way  = victim_way;
            ctl_cmd.set  = SET_MAX_W'(req_set);
            ctl_cmd.line = rd_data;
            ctl_cmd.tag  = TAG_MAX_W'(req.addr.raw[ADDR_W-1 -: TAG_W]);
            ctl_cmd.err  = rd_err;
        end
    end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; #(
    parameter int SET_BITS = DEF_SET_BITS
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          req,
    input  logic              fence,
    output logic              ok,
    output logic [WORD_W-1:0] rdata,
    output logic              rdata_err,
    output logic              rd_req,
    output logic [ADDR_W-1:0] rd_addr,
    input  logic              rd_ready,
    input  logic              rd_err,
    input  logic [LINE_W-1:0] rd_data,
    output logic              wr_req,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [LINE_W-1:0] wr_data,
    input  logic              wr_ready
);
    line_meta_t           meta0;
    line_meta_t           meta1;
    logic                 recent;
    logic                 busy;
    logic                 hit_way;
    logic                 miss;
    logic                 victim_way;
    logic                 victim_dirty;
    arr_wr_t              lk_cmd;
    arr_wr_t              ctl_cmd;
    arr_wr_t              arr_cmd;
    logic [SET_BITS:0]    wb_sel;
    logic [LINE_W-1:0]    wb_line;
    logic [TAG_MAX_W-1:0] wb_tag;
    logic                 wb_dirty;
    logic [SET_BITS-1:0]  req_set;
    logic                 rd_hit;

    assign req_set = req.addr.raw[OFFS_W+BYTE_W +: SET_BITS];
    assign rd_hit  = ok && !req.write;
    assign arr_cmd = (ctl_cmd.kind != WR_NONE) ? ctl_cmd : lk_cmd; // Controller first

    dcache_lookup #(.SET_BITS(SET_BITS)) u_lookup (
        .clk(clk), .rst(rst), .req(req), .meta0(meta0), .meta1(meta1), .recent(recent),
        .busy(busy), .ok(ok), .hit_way(hit_way), .miss(miss), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .lk_cmd(lk_cmd)
    );

    dcache_arrays #(.SET_BITS(SET_BITS)) u_arrays (
        .clk(clk), .rst(rst), .set(req_set), .cmd(arr_cmd), .rd_en(rd_hit),
        .rd_way(hit_way), .rd_offs(req.addr.f.offs), .wb_sel(wb_sel), .meta0(meta0),
        .meta1(meta1), .recent(recent), .rdata(rdata), .rdata_err(rdata_err),
        .wb_line(wb_line), .wb_tag(wb_tag), .wb_dirty(wb_dirty)
    );

    dcache_miss_ctrl #(.SET_BITS(SET_BITS)) u_miss_ctrl (
        .clk(clk), .rst(rst), .req(req), .miss(miss), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .fence(fence), .wb_line(wb_line), .wb_tag(wb_tag),
        .wb_dirty(wb_dirty), .busy(busy), .wb_sel(wb_sel), .ctl_cmd(ctl_cmd),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ready(rd_ready), .rd_err(rd_err),
        .rd_data(rd_data), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_ready(wr_ready)
    );

endmodule

/* tb/mem_line_model.sv */
`timescale 1ns/100ps

module mem_line_model import dcache_pkg::*; #(
    parameter int                MAX_DELAY = 3,
    parameter logic [ADDR_W-1:0] ERR_ADDR  = 64'h1a00,
    parameter int                LINES     = 512
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_ready,
    output logic              rd_err,
    output logic [LINE_W-1:0] rd_data,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LINE_W-1:0] wr_data,
    output logic              wr_ready
);
    localparam int IDX_W = $clog2(LINES);

    logic [LINE_W-1:0] mem [LINES]; // Loaded by the testbench
    int                dly;

    assign rd_data = mem[rd_addr[4 +: IDX_W]];
    assign rd_err  = rd_req && (rd_addr == ERR_ADDR); // One poisoned line

    // Ready pulse after 0 to MAX_DELAY cycles, driven on the falling edge
    initial begin
        rd_ready = 1'b0;
        wr_ready = 1'b0;
        dly      = -1;
        forever begin
            @(negedge clk);
            rd_ready = 1'b0;
            wr_ready = 1'b0;
            if (rst || !(rd_req || wr_req)) begin
                dly = -1;
            end else begin
                if (dly < 0)
                    dly = $urandom_range(MAX_DELAY, 0);
                if (dly == 0) begin
                    rd_ready = rd_req;
                    wr_ready = wr_req;
                    dly      = -1;
                end else begin
                    dly = dly - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (wr_req && wr_ready)
            mem[wr_addr[4 +: IDX_W]] <= wr_data;
    end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();
    localparam int ROWS  = 18;
    localparam int LIMIT = 200 * ROWS;
    localparam int LINES = 512;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_FENCE} op_e;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr; // Probe read address for a fence
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
        logic [WORD_W-1:0] exp_data;
        logic              exp_err;
        logic [3:0]        n_rd; // Line reads expected in the row
        logic [3:0]        n_wr;
    } row_t;

    logic              clk;
    logic              rst;
    cpu_req_t          req;
    logic              fence;
    logic              ok;
    logic [WORD_W-1:0] rdata;
    logic              rdata_err;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_ready;
    logic              rd_err;
    logic [LINE_W-1:0] rd_data;
    logic              wr_req;
    logic [ADDR_W-1:0] wr_addr;
    logic [LINE_W-1:0] wr_data;
    logic              wr_ready;

    row_t              tbl [ROWS];
    logic [7:0]        shadow [LINES*16];
    int                cycles  = 0;
    int                rd_seen = 0;
    int                wr_seen = 0;

    dcache_top #(.SET_BITS(DEF_SET_BITS)) dut0 (.*);

    mem_line_model #(.MAX_DELAY(3), .ERR_ADDR(64'h1a00), .LINES(LINES)) mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            report_fail();
        end
    endtask

    function automatic logic [7:0] pattern(input int a);
        return 8'(a ^ (a >> 8) ^ 8'h5a); // Every address bit matters
    endfunction

    task automatic fill_pattern();
        for (int a = 0; a < LINES*16; a++)
            shadow[a] = pattern(a);
    endtask

    function automatic logic [WORD_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        logic [WORD_W-1:0] w;
        for (int b = 0; b < 8; b++)
            w[b*8 +: 8] = shadow[{addr[12:3], 3'(b)}];
        return w;
    endfunction

    task automatic merge_store(input row_t r);
        for (int b = 0; b < 8; b++)
            if (r.strb[b])
                shadow[{r.addr[12:3], 3'(b)}] = r.wdata[b*8 +: 8];
    endtask

    function automatic logic [LINE_W-1:0] line_of(input int idx);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < 16; b++)
            l[b*8 +: 8] = shadow[idx*16 + b];
        return l;
    endfunction

    function automatic row_t make_row(input op_e op, input logic [ADDR_W-1:0] addr,
                                      input logic [STRB_W-1:0] strb,
                                      input logic [WORD_W-1:0] wdata, input logic err,
                                      input int n_rd, input int n_wr);
        return '{op, addr, strb, wdata, '0, err, 4'(n_rd), 4'(n_wr)};
    endfunction

    task automatic wait_ok();
        do
            @(posedge clk);
        while (!ok);
    endtask

    always @(posedge clk) begin
        cycles++;
        assert (cycles < LIMIT) else begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            report_fail();
        end
    end

    // Line reads follow the request, write-backs carry the newest line contents
    always @(posedge clk) begin
        if (rd_req && rd_ready) begin
            rd_seen++;
            check_value("rd_addr", rd_addr, {req.addr.raw[ADDR_W-1:4], 4'h0});
        end
        if (wr_req && wr_ready) begin
            wr_seen++;
            check_value("wr_addr[3:0]", wr_addr[3:0], 0);
            check_value("wr_data", wr_data, line_of(int'(wr_addr[12:4])));
        end
    end

    initial begin
        void'($urandom(32'h32a8));
        rst   = 1'b1;
        fence = 1'b0;
        req   = '0;
        req.valid    = 1'b1; // Read held through reset
        req.addr.raw = 64'h0108;

        tbl[0]  = make_row(OP_RD, 64'h0108, 8'h00, 64'h0, 1'b0, 1, 0); // Cold miss
        tbl[1]  = make_row(OP_RD, 64'h0100, 8'h00, 64'h0, 1'b0, 0, 0);
        tbl[2]  = make_row(OP_WR, 64'h0100, 8'h0f, 64'h1111_2222_3333_4444, 1'b0, 0, 0);
        tbl[3]  = make_row(OP_WR, 64'h0100, 8'ha0, 64'haaaa_bbbb_cccc_dddd, 1'b0, 0, 0);
        tbl[4]  = make_row(OP_RD, 64'h0100, 8'h00, 64'h0, 1'b0, 0, 0);
        tbl[5]  = make_row(OP_RD, 64'h0900, 8'h00, 64'h0, 1'b0, 1, 0); // Fills way 1
        tbl[6]  = make_row(OP_WR, 64'h0908, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0, 0, 0);
        tbl[7]  = make_row(OP_RD, 64'h1100, 8'h00, 64'h0, 1'b0, 1, 1); // LRU dirty out
        tbl[8]  = make_row(OP_RD, 64'h0100, 8'h00, 64'h0, 1'b0, 1, 0); // Clean way out
        tbl[9]  = make_row(OP_WR, 64'h0240, 8'h3c, 64'h5555_6666_7777_8888, 1'b0, 1, 0);
        tbl[10] = make_row(OP_WR, 64'h0488, 8'hff, 64'hfeed_face_dead_beef, 1'b0, 1, 0);
        tbl[11] = make_row(OP_FENCE, 64'h0240, 8'h00, 64'h0, 1'b0, 0, 3);
        tbl[12] = make_row(OP_FENCE, 64'h0488, 8'h00, 64'h0, 1'b0, 0, 0); // Nothing dirty
        tbl[13] = make_row(OP_RD, 64'h1a00, 8'h00, 64'h0, 1'b1, 1, 0); // Bus error
        tbl[14] = make_row(OP_RD, 64'h1a08, 8'h00, 64'h0, 1'b1, 0, 0);
        tbl[15] = make_row(OP_RD, 64'h0100, 8'h00, 64'h0, 1'b0, 0, 0);
        tbl[16] = make_row(OP_WR, 64'h0908, 8'h81, 64'h9900_0000_0000_0077, 1'b0, 0, 0);
        tbl[17] = make_row(OP_RD, 64'h0908, 8'h00, 64'h0, 1'b0, 0, 0);

        fill_pattern();
        for (int i = 0; i < ROWS; i++) begin
            if (tbl[i].op == OP_WR)
                merge_store(tbl[i]);
            else
                tbl[i].exp_data = read_word(tbl[i].addr);
        end
        fill_pattern(); // Memory and shadow start equal
        for (int i = 0; i < LINES; i++)
            mem0.mem[i] = line_of(i);

        repeat (10) begin
            @(negedge clk);
            check_value("ok", ok, 0);
            check_value("rd_req", rd_req, 0);
            check_value("wr_req", wr_req, 0);
        end
        rst       = 1'b0;
        req.valid = 1'b0;

        for (int i = 0; i < ROWS; i++) begin
            int rd0;
            int wr0;
            rd0 = rd_seen;
            wr0 = wr_seen;
            @(negedge clk);
            if (tbl[i].op == OP_FENCE) begin
                fence = 1'b1;
                @(negedge clk);
                fence = 1'b0;
            end
            req.valid    = 1'b1;
            req.write    = (tbl[i].op == OP_WR);
            req.addr.raw = tbl[i].addr;
            req.strb     = tbl[i].strb;
            req.wdata    = tbl[i].wdata;
            wait_ok();
            if (tbl[i].op == OP_WR)
                merge_store(tbl[i]); // Store lands on this edge
            @(negedge clk);
            req.valid = 1'b0;
            if (tbl[i].op != OP_WR) begin
                check_value("rdata", rdata, tbl[i].exp_data);
                check_value("rdata_err", rdata_err, tbl[i].exp_err);
            end
            check_value("rd_req handshakes", rd_seen - rd0, tbl[i].n_rd);
            check_value("wr_req handshakes", wr_seen - wr0, tbl[i].n_wr);
            if (tbl[i].op == OP_FENCE) begin
                for (int l = 0; l < LINES; l++)
                    check_value($sformatf("mem0.mem[%0d]", l), mem0.mem[l], line_of(l));
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, the verdict comes from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_dcache -f dcache.f \
    -o sim_dcache > build.log 2>&1 &&
{ ./obj_dir/sim_dcache > sim.log 2>&1; cat sim.log; } &&
! grep -q "STATUS: FAIL" sim.log &&
grep -q "STATUS: PASS" sim.log ||
{ echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

/* dcache.f */
common/dcache_pkg.sv
dcache/dcache_lookup.sv
dcache/dcache_arrays.sv
dcache/dcache_miss_ctrl.sv
hdl/dcache_top.sv
tb/mem_line_model.sv
tb/tb_dcache.sv
